//--- sources.f
+incdir+include
hw/hl2_ctrl_pkg.sv
hw/ms_tick_gen.sv
hw/led_stretch.sv
hw/status_leds.sv
hw/rf_ctrl.sv
hw/telemetry_framer.sv
hw/hl2_io_ctrl.sv
sim/tb_hl2_io_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_hl2_io_ctrl
FILELIST  := sources.f
VFLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

# Sources from the file list plus the included headers
SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Pass only when the log holds the pass line
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Running totals across the whole run
int tb_pass_cnt = 0;
int tb_fail_cnt = 0;

// Single-bit compare
task automatic check_bit(
  input string name,
  input logic  got,
  input logic  exp
);
  if (got !== exp) begin
    tb_fail_cnt++;
    $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
  end else begin
    tb_pass_cnt++;
  end
endtask

// Full response word compare
task automatic check_resp(
  input string                    name,
  input hl2_ctrl_pkg::resp_word_t got,
  input hl2_ctrl_pkg::resp_word_t exp
);
  if (got !== exp) begin
    tb_fail_cnt++;
    $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
  end else begin
    tb_pass_cnt++;
  end
endtask

// One analog reading
task automatic check_adc(
  input string                   name,
  input hl2_ctrl_pkg::adc_word_t got,
  input hl2_ctrl_pkg::adc_word_t exp
);
  if (got !== exp) begin
    tb_fail_cnt++;
    $display("ERROR: %s got %h expected %h at %0t", name, got, exp, $time);
  end else begin
    tb_pass_cnt++;
  end
endtask

// Closing summary line
task automatic report_checks();
  $display("Checks: %0d passed, %0d failed", tb_pass_cnt, tb_fail_cnt);
endtask

`endif

//--- sim/tb_hl2_io_ctrl.sv
`timescale 1ns/1ns

module tb_hl2_io_ctrl;

  import hl2_ctrl_pkg::*;

  localparam int         MS_DIV         = 8;
  localparam int         STRETCH_BITS   = 2;
  localparam int         BLINK_BIT      = 3;
  localparam logic [7:0] VERSION        = 8'h4d;
  localparam int         STRETCH_PERIOD = MS_DIV << STRETCH_BITS;
  localparam int         BLINK_PERIOD   = 2 * MS_DIV * (1 << BLINK_BIT);
  localparam logic [8:0] STRETCH_MASK   = 9'((1 << STRETCH_BITS) - 1);
  localparam int         PAT_OFF        = 0;
  localparam int         PAT_SOLID      = 1;
  localparam int         PAT_BLINK      = 2;

  `include "tb_checks.svh"

  logic       clk;
  logic       slow_adc_rst;
  logic       run;
  logic       ethup;
  logic       have_dhcp_ip;
  logic       have_fixed_ip;
  net_speed_t net_speed;
  logic       ad9866up;
  logic       rxgoodlvl;
  logic       rxclip;
  logic       cmd_rqst;
  cmd_addr_t  cmd_addr;
  cmd_data_t  cmd_data;
  logic       cmd_ptt;
  logic       ext_ptt;
  logic       tx_hang;
  logic       tx_inhibit;
  logic       resp_rqst;
  logic [7:0] dsiq_status;
  adc_word_t  fwd_pwr;
  adc_word_t  rev_pwr;
  adc_word_t  bias;
  adc_word_t  temp;

  logic       led_run_n;
  logic       led_tx_n;
  logic       led_adc75_n;
  logic       led_adc100_n;
  logic       tx_on;
  logic       pwr_envpa;
  logic       pwr_envop;
  logic       pwr_envbias;
  logic       pa_inttr;
  logic       pa_exttr;
  logic       rfsw_sel;
  logic       hl2_reset;
  resp_word_t resp;
  logic       dsiq_sample;

  // Reference model state
  int         m_div;
  logic [8:0] m_ms_cnt;
  logic       m_flash;
  logic       m_int_ptt;
  logic       m_vna;
  logic       m_pa_en;
  logic       m_tr_dis;
  logic       m_reload;
  logic       m_ptt_resp;
  slot_t      m_slot;
  logic [1:0] m_clip;
  resp_word_t m_resp;
  logic       m_dsiq;
  adc_word_t  m_adc_hi;
  adc_word_t  m_adc_lo;
  int         m_slot1_words;

  int         test_fail_base;

  hl2_io_ctrl #(
    .MS_DIV        (MS_DIV),
    .STRETCH_BITS  (STRETCH_BITS),
    .BLINK_BIT     (BLINK_BIT),
    .VERSION_MAJOR (VERSION)
  ) DUT (
    .clk             (clk),
    .slow_adc_rst    (slow_adc_rst),
    .run_i           (run),
    .ethup_i         (ethup),
    .have_dhcp_ip_i  (have_dhcp_ip),
    .have_fixed_ip_i (have_fixed_ip),
    .network_speed_i (net_speed),
    .ad9866up_i      (ad9866up),
    .rxgoodlvl_i     (rxgoodlvl),
    .rxclip_i        (rxclip),
    .cmd_rqst_i      (cmd_rqst),
    .cmd_addr_i      (cmd_addr),
    .cmd_data_i      (cmd_data),
    .cmd_ptt_i       (cmd_ptt),
    .ext_ptt_i       (ext_ptt),
    .tx_hang_i       (tx_hang),
    .tx_inhibit_i    (tx_inhibit),
    .resp_rqst_i     (resp_rqst),
    .dsiq_status_i   (dsiq_status),
    .fwd_pwr_i       (fwd_pwr),
    .rev_pwr_i       (rev_pwr),
    .bias_i          (bias),
    .temp_i          (temp),
    .io_led_run_o    (led_run_n),
    .io_led_tx_o     (led_tx_n),
    .io_led_adc75_o  (led_adc75_n),
    .io_led_adc100_o (led_adc100_n),
    .tx_on_o         (tx_on),
    .pwr_envpa_o     (pwr_envpa),
    .pwr_envop_o     (pwr_envop),
    .pwr_envbias_o   (pwr_envbias),
    .pa_inttr_o      (pa_inttr),
    .pa_exttr_o      (pa_exttr),
    .rffe_rfsw_sel_o (rfsw_sel),
    .hl2_reset_o     (hl2_reset),
    .resp_o          (resp),
    .dsiq_sample_o   (dsiq_sample)
  );

  always #2 clk = ~clk;

  function automatic logic rand_bit(input int pct);
    return ($urandom % 100) < pct;
  endfunction

  // Expected slot word built from the response format
  function automatic resp_word_t slot_word(input slot_t s, input logic clip_full,
                                           input logic ptt);
    logic [7:0]  hdr;
    logic [31:0] pl;
    hdr = {3'b000, s, 2'b00, ptt};
    case (s)
      2'd0: pl = {7'b0001111, clip_full, 8'h00, dsiq_status, VERSION};
      2'd1: pl = {4'h0, temp, 4'h0, fwd_pwr};
      2'd2: pl = {4'h0, rev_pwr, 4'h0, bias};
      default: pl = 32'h0;
    endcase
    return {hdr, pl};
  endfunction

  // Cycle model of timebase, command registers and framer
  always @(posedge clk) begin
    if (slow_adc_rst) begin
      m_div      <= 0;
      m_ms_cnt   <= '0;
      m_flash    <= 1'b0;
      m_int_ptt  <= 1'b0;
      m_vna      <= 1'b0;
      m_pa_en    <= 1'b0;
      m_tr_dis   <= 1'b0;
      m_reload   <= 1'b0;
      m_ptt_resp <= 1'b0;
      m_slot     <= '0;
      m_clip     <= '0;
      m_resp     <= '0;
      m_dsiq     <= 1'b0;
    end else begin
      if (m_div == MS_DIV - 1) begin
        m_div    <= 0;
        m_ms_cnt <= m_ms_cnt + 9'd1;
        m_flash  <= ((m_ms_cnt + 9'd1) & STRETCH_MASK) == STRETCH_MASK;
      end else begin
        m_div   <= m_div + 1;
        m_flash <= 1'b0;
      end
      if (cmd_rqst) begin
        m_int_ptt <= cmd_ptt;
        if (cmd_addr == CMD_ADDR_TXCFG) begin
          m_vna    <= cmd_data[23];
          m_pa_en  <= cmd_data[19];
          m_tr_dis <= cmd_data[18];
        end else if (cmd_addr == CMD_ADDR_RELOAD) begin
          m_reload <= cmd_data[0];
        end
      end
      m_ptt_resp <= ext_ptt;
      if (resp_rqst) begin
        m_resp <= slot_word(m_slot, m_clip == 2'd3, m_ptt_resp);
        m_slot <= m_slot + 2'd1;
        m_clip <= 2'd0;
        m_adc_hi <= (m_slot == 2'd1) ? temp : rev_pwr;
        m_adc_lo <= (m_slot == 2'd1) ? fwd_pwr : bias;
        if (m_slot == 2'd1) begin
          m_dsiq        <= ~m_dsiq;
          m_slot1_words <= m_slot1_words + 1;
        end
      end else if (m_clip != 2'd3 && rxclip) begin
        m_clip <= m_clip + 2'd1;
      end
    end
  end

  task automatic open_test();
    test_fail_base = tb_fail_cnt;
  endtask

  task automatic close_test(input string name);
    if (tb_fail_cnt == test_fail_base) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, tb_fail_cnt - test_fail_base);
    end
  endtask

  task automatic note_timeout(input string what);
    tb_fail_cnt++;
    $display("Timed out waiting for %s at %0t", what, $time);
  endtask

  // Transmit gating and PA switching against the current model registers
  task automatic check_rf();
    logic e_tx;
    logic pa_path;
    e_tx    = (m_int_ptt | ext_ptt | tx_hang) & ~tx_inhibit & run;
    pa_path = ~m_vna & m_pa_en;
    check_bit("tx_on_o", tx_on, e_tx);
    check_bit("pwr_envop_o", pwr_envop, e_tx);
    check_bit("pa_exttr_o", pa_exttr, e_tx);
    check_bit("pwr_envpa_o", pwr_envpa, e_tx & pa_path);
    check_bit("pwr_envbias_o", pwr_envbias, e_tx & pa_path);
    check_bit("pa_inttr_o", pa_inttr, e_tx & ~m_vna & (m_pa_en | ~m_tr_dis));
    check_bit("rffe_rfsw_sel_o", rfsw_sel, pa_path);
    check_bit("hl2_reset_o", hl2_reset, m_reload & ~run);
  endtask

  task automatic check_idle_leds();
    logic b;
    b = m_ms_cnt[BLINK_BIT];
    check_bit("io_led_run_o", led_run_n, ~(ethup & b));
    check_bit("io_led_tx_o", led_tx_n, ~(have_dhcp_ip | (have_fixed_ip & b)));
    check_bit("io_led_adc75_o", led_adc75_n,
              ~(((net_speed == NET_100M) & b) | (net_speed == NET_1G)));
    check_bit("io_led_adc100_o", led_adc100_n, ~ad9866up);
  endtask

  function automatic string pat_name(input int kind);
    case (kind)
      PAT_OFF:   return "off";
      PAT_SOLID: return "solid";
      default:   return "blinking";
    endcase
  endfunction

  task automatic check_pattern(input string name, input int lit, input int total,
                               input int kind);
    int got;
    got = (lit == 0) ? PAT_OFF : ((lit == total) ? PAT_SOLID : PAT_BLINK);
    if (got != kind) begin
      tb_fail_cnt++;
      $display("%s was %s but should be %s", name, pat_name(got), pat_name(kind));
    end else begin
      tb_pass_cnt++;
    end
  endtask

  task automatic wait_run_led_fall(output int cycles, output bit found);
    logic prev;
    prev   = led_run_n;
    cycles = 0;
    found  = 1'b0;
    while (!found && cycles < 4 * BLINK_PERIOD) begin
      @(negedge clk);
      cycles++;
      check_idle_leds();
      if (prev && !led_run_n) begin
        found = 1'b1;
      end
      prev = led_run_n;
    end
    if (!found) begin
      note_timeout("a falling edge on the run LED");
    end
  endtask

  task automatic send_cmd(input cmd_addr_t addr, input cmd_data_t data);
    @(posedge clk);
    cmd_rqst <= 1'b1;
    cmd_addr <= addr;
    cmd_data <= data;
    cmd_ptt  <= 1'b0;
    @(posedge clk);
    cmd_rqst <= 1'b0;
    @(negedge clk);
    check_rf();
  endtask

  task automatic test_reset_blink();
    int  cycles;
    bit  ok_a;
    bit  ok_b;
    open_test();
    @(negedge clk);
    check_rf();
    check_bit("tx_on_o", tx_on, 1'b0);
    check_bit("hl2_reset_o", hl2_reset, 1'b0);
    check_bit("io_led_run_o", led_run_n, 1'b1);
    check_bit("io_led_tx_o", led_tx_n, 1'b1);
    check_bit("io_led_adc75_o", led_adc75_n, 1'b1);
    check_bit("io_led_adc100_o", led_adc100_n, 1'b1);
    check_bit("dsiq_sample_o", dsiq_sample, 1'b0);
    check_resp("resp_o", resp, '0);
    @(posedge clk);
    ethup <= 1'b1;
    wait_run_led_fall(cycles, ok_a);
    if (ok_a) begin
      wait_run_led_fall(cycles, ok_b);
      if (ok_b && cycles != BLINK_PERIOD) begin
        tb_fail_cnt++;
        $display("Run LED blink period was %0d cycles, should be %0d", cycles, BLINK_PERIOD);
      end
    end
    @(posedge clk);
    ethup <= 1'b0;
    close_test("reset and blink");
  endtask

  task automatic test_rf_random();
    open_test();
    repeat (300) begin
      @(posedge clk);
      cmd_rqst <= rand_bit(50);
      case ($urandom % 3)
        0: cmd_addr <= CMD_ADDR_TXCFG;
        1: cmd_addr <= CMD_ADDR_RELOAD;
        default: cmd_addr <= cmd_addr_t'($urandom);
      endcase
      cmd_data   <= $urandom;
      cmd_ptt    <= rand_bit(50);
      ext_ptt    <= rand_bit(30);
      tx_hang    <= rand_bit(20);
      tx_inhibit <= rand_bit(20);
      run        <= rand_bit(70);
      @(negedge clk);
      check_rf();
    end
    @(posedge clk);
    cmd_rqst   <= 1'b0;
    ext_ptt    <= 1'b0;
    tx_hang    <= 1'b0;
    tx_inhibit <= 1'b0;
    run        <= 1'b0;
    close_test("random commands");
  endtask

  task automatic test_reload();
    open_test();
    send_cmd(CMD_ADDR_RELOAD, 32'h0000_0001);
    check_bit("hl2_reset_o", hl2_reset, 1'b1);
    @(posedge clk);
    run <= 1'b1;
    @(negedge clk);
    check_bit("hl2_reset_o", hl2_reset, 1'b0);
    @(posedge clk);
    run <= 1'b0;
    @(negedge clk);
    check_bit("hl2_reset_o", hl2_reset, 1'b1);
    // Other addresses leave the reload bit alone
    send_cmd(6'h05, 32'h0000_0000);
    check_bit("hl2_reset_o", hl2_reset, 1'b1);
    send_cmd(CMD_ADDR_RELOAD, 32'h0000_0000);
    check_bit("hl2_reset_o", hl2_reset, 1'b0);
    close_test("flash reload");
  endtask

  task automatic test_telemetry();
    logic prev_dsiq;
    int   toggles;
    int   slot1_base;
    open_test();
    prev_dsiq  = dsiq_sample;
    toggles    = 0;
    slot1_base = m_slot1_words;
    repeat (400) begin
      @(posedge clk);
      resp_rqst   <= rand_bit(30);
      rxclip      <= rand_bit(25);
      ext_ptt     <= rand_bit(50);
      dsiq_status <= 8'($urandom);
      fwd_pwr     <= adc_word_t'($urandom);
      rev_pwr     <= adc_word_t'($urandom);
      bias        <= adc_word_t'($urandom);
      temp        <= adc_word_t'($urandom);
      @(negedge clk);
      check_resp("resp_o", resp, m_resp);
      check_bit("dsiq_sample_o", dsiq_sample, m_dsiq);
      if (m_resp[36:35] == 2'd1 || m_resp[36:35] == 2'd2) begin
        check_adc("resp_o high reading", resp[27:16], m_adc_hi);
        check_adc("resp_o low reading", resp[11:0], m_adc_lo);
      end
      if (dsiq_sample !== prev_dsiq) begin
        toggles++;
      end
      prev_dsiq = dsiq_sample;
    end
    @(posedge clk);
    resp_rqst <= 1'b0;
    rxclip    <= 1'b0;
    ext_ptt   <= 1'b0;
    @(negedge clk);
    // The last request of the loop lands here
    check_resp("resp_o", resp, m_resp);
    check_bit("dsiq_sample_o", dsiq_sample, m_dsiq);
    if (dsiq_sample !== prev_dsiq) begin
      toggles++;
    end
    if (toggles != m_slot1_words - slot1_base) begin
      tb_fail_cnt++;
      $display("IQ sample toggled %0d times for %0d slot 1 words", toggles,
               m_slot1_words - slot1_base);
    end
    close_test("telemetry slots");
  endtask

  task automatic check_stretch(input int ch);
    int   guard;
    int   lit;
    int   ticks;
    bit   done;
    logic own;
    logic other;
    guard = 0;
    // Let any earlier stretch run out first
    do begin
      @(negedge clk);
      guard++;
    end while ((!led_adc75_n || !led_adc100_n) && guard < 8 * STRETCH_PERIOD);
    if (!led_adc75_n || !led_adc100_n) begin
      note_timeout("the stretched LEDs to go dark");
      return;
    end
    @(posedge clk);
    if (ch == 0) begin
      rxgoodlvl <= 1'b1;
    end else begin
      rxclip <= 1'b1;
    end
    @(posedge clk);
    rxgoodlvl <= 1'b0;
    rxclip    <= 1'b0;
    lit   = 0;
    ticks = 0;
    done  = 1'b0;
    while (!done && lit <= 4 * STRETCH_PERIOD) begin
      @(negedge clk);
      own   = (ch == 0) ? led_adc75_n : led_adc100_n;
      other = (ch == 0) ? led_adc100_n : led_adc75_n;
      if (!own) begin
        lit++;
        if (m_flash) begin
          ticks++;
        end
        check_bit((ch == 0) ? "io_led_adc100_o" : "io_led_adc75_o", other, 1'b1);
      end else begin
        done = 1'b1;
      end
    end
    if (!done) begin
      note_timeout("a stretched LED to go dark again");
    end else if (lit < 2 * STRETCH_PERIOD || lit > 3 * STRETCH_PERIOD || ticks != 3) begin
      tb_fail_cnt++;
      $display("Channel %0d LED lit for %0d cycles over %0d flash ticks", ch, lit, ticks);
    end else begin
      tb_pass_cnt++;
    end
  endtask

  task automatic test_stretch();
    open_test();
    @(posedge clk);
    run <= 1'b1;
    check_stretch(0);
    check_stretch(1);
    @(posedge clk);
    run <= 1'b0;
    close_test("status stretch");
  endtask

  task automatic test_idle_leds();
    int sp;
    int combo;
    int lit_run;
    int lit_tx;
    int lit_75;
    int lit_100;
    int total;
    open_test();
    total = BLINK_PERIOD + 2;
    for (sp = 0; sp < 3; sp++) begin
      for (combo = 0; combo < 16; combo++) begin
        @(posedge clk);
        case (sp)
          0: net_speed <= NET_NONE;
          1: net_speed <= NET_100M;
          default: net_speed <= NET_1G;
        endcase
        ethup         <= combo[0];
        have_dhcp_ip  <= combo[1];
        have_fixed_ip <= combo[2];
        ad9866up      <= combo[3];
        lit_run = 0;
        lit_tx  = 0;
        lit_75  = 0;
        lit_100 = 0;
        repeat (total) begin
          @(negedge clk);
          check_idle_leds();
          lit_run += !led_run_n;
          lit_tx  += !led_tx_n;
          lit_75  += !led_adc75_n;
          lit_100 += !led_adc100_n;
        end
        check_pattern("run LED", lit_run, total, combo[0] ? PAT_BLINK : PAT_OFF);
        check_pattern("tx LED", lit_tx, total,
                      combo[1] ? PAT_SOLID : (combo[2] ? PAT_BLINK : PAT_OFF));
        check_pattern("adc75 LED", lit_75, total,
                      (sp == 2) ? PAT_SOLID : ((sp == 1) ? PAT_BLINK : PAT_OFF));
        check_pattern("adc100 LED", lit_100, total, combo[3] ? PAT_SOLID : PAT_OFF);
      end
    end
    close_test("idle LED patterns");
  endtask

  initial begin
    void'($urandom(32'h2514_f77f));
    clk           = 1'b0;
    slow_adc_rst  = 1'b1;
    run           = 1'b0;
    ethup         = 1'b0;
    have_dhcp_ip  = 1'b0;
    have_fixed_ip = 1'b0;
    net_speed     = NET_NONE;
    ad9866up      = 1'b0;
    rxgoodlvl     = 1'b0;
    rxclip        = 1'b0;
    cmd_rqst      = 1'b0;
    cmd_addr      = '0;
    cmd_data      = '0;
    cmd_ptt       = 1'b0;
    ext_ptt       = 1'b0;
    tx_hang       = 1'b0;
    tx_inhibit    = 1'b0;
    resp_rqst     = 1'b0;
    dsiq_status   = '0;
    fwd_pwr       = '0;
    rev_pwr       = '0;
    bias          = '0;
    temp          = '0;
    m_slot1_words = 0;
    repeat (2) @(posedge clk);
    slow_adc_rst <= 1'b0;
    test_reset_blink();
    test_rf_random();
    test_reload();
    test_telemetry();
    test_stretch();
    test_idle_leds();
    report_checks();
    if (tb_fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- hw/hl2_io_ctrl.sv
`timescale 1ns/1ns

module hl2_io_ctrl #(
  parameter int         MS_DIV        = 2500,
  parameter int         STRETCH_BITS  = 6,
  parameter int         BLINK_BIT     = 8,
  parameter logic [7:0] VERSION_MAJOR = 8'h00
) (
  input  logic                     clk,
  input  logic                     slow_adc_rst,
  input  logic                     run_i,
  input  logic                     ethup_i,
  input  logic                     have_dhcp_ip_i,
  input  logic                     have_fixed_ip_i,
  input  hl2_ctrl_pkg::net_speed_t network_speed_i,
  input  logic                     ad9866up_i,
  input  logic                     rxgoodlvl_i,
  input  logic                     rxclip_i,
  input  logic                     cmd_rqst_i,
  input  hl2_ctrl_pkg::cmd_addr_t  cmd_addr_i,
  input  hl2_ctrl_pkg::cmd_data_t  cmd_data_i,
  input  logic                     cmd_ptt_i,
  input  logic                     ext_ptt_i,
  input  logic                     tx_hang_i,
  input  logic                     tx_inhibit_i,
  input  logic                     resp_rqst_i,
  input  logic [7:0]               dsiq_status_i,
  input  hl2_ctrl_pkg::adc_word_t  fwd_pwr_i,
  input  hl2_ctrl_pkg::adc_word_t  rev_pwr_i,
  input  hl2_ctrl_pkg::adc_word_t  bias_i,
  input  hl2_ctrl_pkg::adc_word_t  temp_i,
  output logic                     io_led_run_o,
  output logic                     io_led_tx_o,
  output logic                     io_led_adc75_o,
  output logic                     io_led_adc100_o,
  output logic                     tx_on_o,
  output logic                     pwr_envpa_o,
  output logic                     pwr_envop_o,
  output logic                     pwr_envbias_o,
  output logic                     pa_inttr_o,
  output logic                     pa_exttr_o,
  output logic                     rffe_rfsw_sel_o,
  output logic                     hl2_reset_o,
  output hl2_ctrl_pkg::resp_word_t resp_o,
  output logic                     dsiq_sample_o
);

  import hl2_ctrl_pkg::*;

  logic               flash_tick;
  logic               blink;
  logic               tx_on;
  logic [N_FLASH-1:0] flash_sig;
  logic [N_FLASH-1:0] flash_n;

  ms_tick_gen #(
    .MS_DIV       (MS_DIV),
    .STRETCH_BITS (STRETCH_BITS),
    .BLINK_BIT    (BLINK_BIT)
  ) u_ms_tick (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .ms_tick_o    (),
    .flash_tick_o (flash_tick),
    .blink_o      (blink)
  );

  // Channel order matches the adc75 and adc100 LEDs
  assign flash_sig = {rxclip_i, rxgoodlvl_i};

  for (genvar i = 0; i < N_FLASH; i++) begin : g_flash
    led_stretch u_stretch (
      .clk          (clk),
      .slow_adc_rst (slow_adc_rst),
      .flash_tick_i (flash_tick),
      .sig_i        (flash_sig[i]),
      .led_n_o      (flash_n[i])
    );
  end

  status_leds u_leds (
    .run_i           (run_i),
    .tx_on_i         (tx_on),
    .blink_i         (blink),
    .ethup_i         (ethup_i),
    .have_dhcp_ip_i  (have_dhcp_ip_i),
    .have_fixed_ip_i (have_fixed_ip_i),
    .network_speed_i (network_speed_i),
    .ad9866up_i      (ad9866up_i),
    .flash_n_i       (flash_n),
    .io_led_run_o    (io_led_run_o),
    .io_led_tx_o     (io_led_tx_o),
    .io_led_adc75_o  (io_led_adc75_o),
    .io_led_adc100_o (io_led_adc100_o)
  );

  rf_ctrl u_rf (
    .clk             (clk),
    .slow_adc_rst    (slow_adc_rst),
    .cmd_rqst_i      (cmd_rqst_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_data_i      (cmd_data_i),
    .cmd_ptt_i       (cmd_ptt_i),
    .ext_ptt_i       (ext_ptt_i),
    .tx_hang_i       (tx_hang_i),
    .tx_inhibit_i    (tx_inhibit_i),
    .run_i           (run_i),
    .tx_on_o         (tx_on),
    .pwr_envpa_o     (pwr_envpa_o),
    .pwr_envop_o     (pwr_envop_o),
    .pwr_envbias_o   (pwr_envbias_o),
    .pa_inttr_o      (pa_inttr_o),
    .pa_exttr_o      (pa_exttr_o),
    .rffe_rfsw_sel_o (rffe_rfsw_sel_o),
    .hl2_reset_o     (hl2_reset_o)
  );

  assign tx_on_o = tx_on;

  telemetry_framer #(
    .VERSION_MAJOR (VERSION_MAJOR)
  ) u_telem (
    .clk           (clk),
    .slow_adc_rst  (slow_adc_rst),
    .resp_rqst_i   (resp_rqst_i),
    .rxclip_i      (rxclip_i),
    .ext_ptt_i     (ext_ptt_i),
    .dsiq_status_i (dsiq_status_i),
    .fwd_pwr_i     (fwd_pwr_i),
    .rev_pwr_i     (rev_pwr_i),
    .bias_i        (bias_i),
    .temp_i        (temp_i),
    .resp_o        (resp_o),
    .dsiq_sample_o (dsiq_sample_o)
  );

endmodule

//--- hw/telemetry_framer.sv
`timescale 1ns/1ns

module telemetry_framer #(
  parameter logic [7:0] VERSION_MAJOR = 8'h00
) (
  input  logic                     clk,
  input  logic                     slow_adc_rst,
  input  logic                     resp_rqst_i,
  input  logic                     rxclip_i,
  input  logic                     ext_ptt_i,
  input  logic [7:0]               dsiq_status_i,
  input  hl2_ctrl_pkg::adc_word_t  fwd_pwr_i,
  input  hl2_ctrl_pkg::adc_word_t  rev_pwr_i,
  input  hl2_ctrl_pkg::adc_word_t  bias_i,
  input  hl2_ctrl_pkg::adc_word_t  temp_i,
  output hl2_ctrl_pkg::resp_word_t resp_o,
  output logic                     dsiq_sample_o
);

  import hl2_ctrl_pkg::*;

  slot_t       slot;
  logic [1:0]  clip_cnt;
  logic        clip_full;
  logic        ptt_resp;
  logic [7:0]  hdr;
  logic [31:0] payload;

  assign clip_full = &clip_cnt;

  // External PTT registered for the response header
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      ptt_resp <= 1'b0;
    end else begin
      ptt_resp <= ext_ptt_i;
    end
  end

  // Common header with the key bit held at zero
  assign hdr = {3'b000, slot, 1'b0, 1'b0, ptt_resp};

  always_comb begin
    case (slot)
      2'd0: payload = {7'b0001111, clip_full, 8'h00, dsiq_status_i, VERSION_MAJOR};
      2'd1: payload = {4'h0, temp_i, 4'h0, fwd_pwr_i};
      2'd2: payload = {4'h0, rev_pwr_i, 4'h0, bias_i};
      default: payload = 32'h0000_0000;
    endcase
  end

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      resp_o   <= '0;
      slot     <= '0;
      clip_cnt <= 2'b00;
    end else if (resp_rqst_i) begin
      resp_o   <= {hdr, payload};
      slot     <= slot + 1'b1;
      clip_cnt <= 2'b00;
    end else if (!clip_full) begin
      // Count clipped cycles until the next request and stick at 3
      clip_cnt <= clip_cnt + {1'b0, rxclip_i};
    end
  end

  // Tell the IQ path a new status sample is wanted
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      dsiq_sample_o <= 1'b0;
    end else if (resp_rqst_i && slot == 2'd1) begin
      dsiq_sample_o <= ~dsiq_sample_o;
    end
  end

endmodule

//--- hw/rf_ctrl.sv
`timescale 1ns/1ns

module rf_ctrl (
  input  logic                    clk,
  input  logic                    slow_adc_rst,
  input  logic                    cmd_rqst_i,
  input  hl2_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  hl2_ctrl_pkg::cmd_data_t cmd_data_i,
  input  logic                    cmd_ptt_i,
  input  logic                    ext_ptt_i,
  input  logic                    tx_hang_i,
  input  logic                    tx_inhibit_i,
  input  logic                    run_i,
  output logic                    tx_on_o,
  output logic                    pwr_envpa_o,
  output logic                    pwr_envop_o,
  output logic                    pwr_envbias_o,
  output logic                    pa_inttr_o,
  output logic                    pa_exttr_o,
  output logic                    rffe_rfsw_sel_o,
  output logic                    hl2_reset_o
);

  import hl2_ctrl_pkg::*;

  logic int_ptt;
  logic vna;
  logic pa_enable;
  logic tr_disable;
  logic reload_req;
  logic tx_on;
  logic pa_path;

  // Host command decode
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      int_ptt    <= 1'b0;
      vna        <= 1'b0;
      pa_enable  <= 1'b0;
      tr_disable <= 1'b0;
      reload_req <= 1'b0;
    end else if (cmd_rqst_i) begin
      // Every command frame carries the host PTT
      int_ptt <= cmd_ptt_i;
      if (cmd_addr_i == CMD_ADDR_TXCFG) begin
        vna        <= cmd_data_i[23];
        pa_enable  <= cmd_data_i[19];
        tr_disable <= cmd_data_i[18];
      end else if (cmd_addr_i == CMD_ADDR_RELOAD) begin
        reload_req <= cmd_data_i[0];
      end
    end
  end

  // Any PTT source keys the transmitter unless inhibited
  assign tx_on = (int_ptt | ext_ptt_i | tx_hang_i) & ~tx_inhibit_i & run_i;

  // Internal PA is used outside VNA mode when enabled
  assign pa_path = ~vna & pa_enable;

  assign tx_on_o         = tx_on;
  assign pwr_envop_o     = tx_on;
  assign pa_exttr_o      = tx_on;
  assign pwr_envpa_o     = tx_on & pa_path;
  assign pwr_envbias_o   = tx_on & pa_path;
  assign pa_inttr_o      = tx_on & ~vna & (pa_enable | ~tr_disable);
  assign rffe_rfsw_sel_o = pa_path;

  // Flash reload only when the radio is idle
  assign hl2_reset_o = reload_req & ~run_i;

endmodule

//--- hw/status_leds.sv
`timescale 1ns/1ns

module status_leds (
  input  logic                              run_i,
  input  logic                              tx_on_i,
  input  logic                              blink_i,
  input  logic                              ethup_i,
  input  logic                              have_dhcp_ip_i,
  input  logic                              have_fixed_ip_i,
  input  hl2_ctrl_pkg::net_speed_t          network_speed_i,
  input  logic                              ad9866up_i,
  input  logic [hl2_ctrl_pkg::N_FLASH-1:0]  flash_n_i,
  output logic                              io_led_run_o,
  output logic                              io_led_tx_o,
  output logic                              io_led_adc75_o,
  output logic                              io_led_adc100_o
);

  import hl2_ctrl_pkg::*;

  logic speed_100m;
  logic speed_1g;

  assign speed_100m = (network_speed_i == NET_100M);
  assign speed_1g   = (network_speed_i == NET_1G);

  // All outputs drive active-low LEDs
  always_comb begin
    if (run_i) begin
      // Radio status once the host has started streaming
      io_led_run_o    = 1'b0;
      io_led_tx_o     = ~tx_on_i;
      io_led_adc75_o  = flash_n_i[0];
      io_led_adc100_o = flash_n_i[1];
    end else begin
      // Blinks while the link is up
      io_led_run_o    = ~(ethup_i & blink_i);
      // Solid for DHCP, blinking for a fixed address
      io_led_tx_o     = ~((have_fixed_ip_i & blink_i) | have_dhcp_ip_i);
      // Blinks at 100M, solid at 1G, dark otherwise
      io_led_adc75_o  = ~((speed_100m & blink_i) | speed_1g);
      io_led_adc100_o = ~ad9866up_i;
    end
  end

endmodule

//--- hw/led_stretch.sv
`timescale 1ns/1ns

module led_stretch (
  input  logic clk,
  input  logic slow_adc_rst,
  input  logic flash_tick_i,
  input  logic sig_i,
  output logic led_n_o
);

  typedef enum logic [1:0] {
    ST_CLR   = 2'b00,
    ST_SET   = 2'b01,
    ST_WAIT1 = 2'b10,
    ST_WAIT2 = 2'b11
  } state_t;

  state_t state;
  state_t state_next;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      state <= ST_CLR;
    end else begin
      state <= state_next;
    end
  end

  // Three flash ticks after a trigger before going dark again
  always_comb begin
    state_next = state;
    case (state)
      ST_CLR: begin
        if (sig_i) begin
          state_next = ST_SET;
        end
      end
      ST_SET: begin
        if (flash_tick_i) begin
          state_next = ST_WAIT1;
        end
      end
      ST_WAIT1: begin
        if (flash_tick_i) begin
          state_next = ST_WAIT2;
        end
      end
      ST_WAIT2: begin
        if (flash_tick_i) begin
          state_next = ST_CLR;
        end
      end
      default: state_next = ST_CLR;
    endcase
  end

  // LED is active low, lit in every state but clear
  assign led_n_o = (state == ST_CLR);

endmodule

//--- hw/ms_tick_gen.sv
`timescale 1ns/1ns

module ms_tick_gen #(
  parameter int MS_DIV       = 2500,
  parameter int STRETCH_BITS = 6,
  parameter int BLINK_BIT    = 8
) (
  input  logic clk,
  input  logic slow_adc_rst,
  output logic ms_tick_o,
  output logic flash_tick_o,
  output logic blink_o
);

  localparam int DIV_W    = (MS_DIV > 1) ? $clog2(MS_DIV) : 1;
  localparam int MS_CNT_W = 9;

  logic [DIV_W-1:0]    div_cnt;
  logic [MS_CNT_W-1:0] ms_cnt;
  logic [MS_CNT_W-1:0] ms_cnt_next;

  assign ms_cnt_next = ms_cnt + 1'b1;

  // Divide the slow clock down to a 1 ms pulse
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      div_cnt      <= '0;
      ms_cnt       <= '0;
      ms_tick_o    <= 1'b0;
      flash_tick_o <= 1'b0;
    end else if (div_cnt == DIV_W'(MS_DIV - 1)) begin
      div_cnt      <= '0;
      ms_cnt       <= ms_cnt_next;
      ms_tick_o    <= 1'b1;
      // Stretch tick when the low bits roll up to all ones
      flash_tick_o <= &ms_cnt_next[STRETCH_BITS-1:0];
    end else begin
      div_cnt      <= div_cnt + 1'b1;
      ms_tick_o    <= 1'b0;
      flash_tick_o <= 1'b0;
    end
  end

  // Slow square wave for blinking LEDs
  assign blink_o = ms_cnt[BLINK_BIT];

endmodule

//--- hw/hl2_ctrl_pkg.sv
package hl2_ctrl_pkg;

  // Host command bus fields
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // One slow analog reading
  typedef logic [11:0] adc_word_t;

  // Response word back to the host, 8-bit header and 32-bit payload
  typedef logic [39:0] resp_word_t;

  // Telemetry slot index
  typedef logic [1:0]  slot_t;

  // Ethernet link speed as reported by the PHY
  typedef enum logic [1:0] {
    NET_NONE = 2'd0,
    NET_100M = 2'd1,
    NET_1G   = 2'd2
  } net_speed_t;

  // TX config register, vna in bit 23, pa_enable in 19, tr_disable in 18
  localparam cmd_addr_t CMD_ADDR_TXCFG  = 6'h09;
  // Bit 0 asks for a reload from configuration flash
  localparam cmd_addr_t CMD_ADDR_RELOAD = 6'h3a;

  // Stretched status channels, 0 is rxgoodlvl and 1 is rxclip
  localparam int N_FLASH = 2;

endpackage
